/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert --timescale 1ns/100ps -j 0
RUN_FLAGS = +verilator+error+limit+1000
TOP       = music_player_tb
FILE_LIST = all.f
LOG       = sim.log
PASS_MSG  = test passed

.PHONY: simulate clean

simulate:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
logic/music_pkg.sv
logic/milli_timer.sv
logic/song_rom.sv
logic/note_sequencer.sv
logic/tone_generator.sv
logic/part_display.sv
logic/music_player.sv
sim/music_player_checker.sv
sim/music_player_tb.sv

/* logic/milli_timer.sv */
module milli_timer
  import music_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic [TPM_W-1:0] ticks_per_milli,
  output logic             milli_tick
);

  logic [TPM_W-1:0] cycle_cnt;  // 0 .. ticks_per_milli
  logic             wrap;

  assign wrap = (cycle_cnt == ticks_per_milli);

  // period is ticks_per_milli + 1 cycles, strobe is registered
  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_cnt  <= '0;
      milli_tick <= 1'b0;
    end else begin
      milli_tick <= wrap;
      if (wrap) begin
        cycle_cnt <= '0;
      end else begin
        cycle_cnt <= cycle_cnt + 1'b1;
      end
    end
  end

endmodule

/* logic/music_pkg.sv */
package music_pkg;

  localparam int FREQ_W  = 10;  // pitch in hz, 0 is silence
  localparam int BEATS_W = 4;   // note length in beats
  localparam int TPM_W   = 16;  // clock ticks per millisecond
  localparam int MS_W    = 12;  // millisecond counters
  localparam int PART_W  = 3;   // part number 1..6
  localparam int IDX_W   = 3;   // note index within a section

  // song sections, parts map onto these
  typedef enum logic [1:0] {
    SEC_INTRO,
    SEC_VERSE,
    SEC_CHORUS
  } section_e;

  // per-note phases of the sequencer
  typedef enum logic [1:0] {
    PH_LOAD,  // one cycle, fetch entry
    PH_PLAY,  // note sounding
    PH_GAP    // silent third
  } phase_e;

  typedef struct packed {
    logic [FREQ_W-1:0]  pitch;  // hz
    logic [BEATS_W-1:0] beats;
  } note_t;

  // seven-segment word, seg[0] is the top bar, clockwise, seg[6] middle
  typedef struct packed {
    logic       dot;  // decimal point
    logic [6:0] seg;
  } led_t;

endpackage

/* logic/music_player.sv */
module music_player
  import music_pkg::*;
#(
  parameter int unsigned BEAT_MS = 100  // tempo, ms per beat
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [TPM_W-1:0] ticks_per_milli,
  output led_t             led,
  output logic             sound
);

  logic              milli_tick;
  logic [PART_W-1:0] part;
  phase_e            phase;
  logic [FREQ_W-1:0] note_freq;

  milli_timer u_milli_timer (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .milli_tick      (milli_tick)
  );

  note_sequencer #(
    .BEAT_MS (BEAT_MS)
  ) u_note_sequencer (
    .clk        (clk),
    .rst        (rst),
    .milli_tick (milli_tick),
    .part       (part),
    .phase      (phase),
    .note_freq  (note_freq)
  );

  tone_generator u_tone_generator (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .note_freq       (note_freq),
    .sound           (sound)
  );

  part_display u_part_display (
    .part  (part),
    .phase (phase),
    .led   (led)
  );

endmodule

/* logic/note_sequencer.sv */
module note_sequencer
  import music_pkg::*;
#(
  parameter int unsigned BEAT_MS = 100  // milliseconds per beat
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              milli_tick,
  output logic [PART_W-1:0] part,
  output phase_e            phase,
  output logic [FREQ_W-1:0] note_freq
);

  section_e          section;
  logic [IDX_W-1:0]  index;
  note_t             rom_note;
  logic              rom_last;
  logic [MS_W-1:0]   ms_cnt;     // ms elapsed in current phase
  logic [MS_W-1:0]   note_len;   // play length in ms
  logic [MS_W-1:0]   base_len;
  logic [MS_W-1:0]   load_len;
  logic [MS_W-1:0]   gap_len;

  // part number to song section
  always_comb begin
    case (part)
      3'd1, 3'd2: section = SEC_INTRO;
      3'd3, 3'd5: section = SEC_VERSE;
      default:    section = SEC_CHORUS;  // parts 4 and 6
    endcase
  end

  song_rom u_song_rom (
    .section (section),
    .index   (index),
    .note    (rom_note),
    .last    (rom_last)
  );

  assign base_len = MS_W'(BEAT_MS * rom_note.beats);
  // verse counts every beat double
  assign load_len = (section == SEC_VERSE) ? (base_len << 1) : base_len;
  assign gap_len  = note_len / 3;

  always_ff @(posedge clk) begin
    if (rst) begin
      part      <= 3'd1;
      index     <= '0;
      phase     <= PH_LOAD;
      ms_cnt    <= '0;
      note_len  <= '0;
      note_freq <= '0;
    end else begin
      case (phase)
        PH_LOAD: begin
          note_len  <= load_len;
          note_freq <= rom_note.pitch;  // rest loads 0, stays silent
          ms_cnt    <= '0;
          phase     <= PH_PLAY;
        end
        PH_PLAY: begin
          if (milli_tick) begin
            if (ms_cnt == note_len) begin
              note_freq <= '0;
              ms_cnt    <= '0;
              phase     <= PH_GAP;
            end else begin
              ms_cnt <= ms_cnt + 1'b1;
            end
          end
        end
        PH_GAP: begin
          if (milli_tick) begin
            if (ms_cnt == gap_len) begin
              ms_cnt <= '0;
              phase  <= PH_LOAD;
              if (rom_last) begin
                index <= '0;
                part  <= (part == 3'd6) ? 3'd1 : part + 1'b1;  // wrap after part 6
              end else begin
                index <= index + 1'b1;
              end
            end else begin
              ms_cnt <= ms_cnt + 1'b1;
            end
          end
        end
        default: begin
          phase <= PH_LOAD;
        end
      endcase
    end
  end

endmodule

/* logic/part_display.sv */
module part_display
  import music_pkg::*;
(
  input  logic [PART_W-1:0] part,
  input  phase_e            phase,
  output led_t              led
);

  // segment bits 6..0 are middle, upper left, lower left, bottom,
  // lower right, upper right, top
  always_comb begin
    case (part)
      3'd1:    led.seg = 7'b0000110;
      3'd2:    led.seg = 7'b1011011;
      3'd3:    led.seg = 7'b1001111;
      3'd4:    led.seg = 7'b1100110;
      3'd5:    led.seg = 7'b1101101;
      3'd6:    led.seg = 7'b1111100;
      default: led.seg = 7'b0000000;  // blank
    endcase
  end

  assign led.dot = (phase == PH_PLAY);  // lit while a note plays

endmodule

/* logic/song_rom.sv */
module song_rom
  import music_pkg::*;
(
  input  section_e         section,
  input  logic [IDX_W-1:0] index,
  output note_t            note,
  output logic             last
);

  always_comb begin
    note = '{10'd0, 4'd0};
    last = 1'b0;
    case (section)
      SEC_INTRO: begin
        last = (index == 3'd3);
        case (index)
          3'd0:    note = '{10'd554, 4'd2};  // c5s
          3'd1:    note = '{10'd622, 4'd2};  // e5f
          3'd2:    note = '{10'd0,   4'd1};  // rest
          3'd3:    note = '{10'd415, 4'd3};  // a4f
          default: note = '{10'd0,   4'd0};
        endcase
      end
      SEC_VERSE: begin
        last = (index == 3'd4);
        case (index)
          3'd0:    note = '{10'd277, 4'd1};  // c4s
          3'd1:    note = '{10'd311, 4'd1};  // e4f
          3'd2:    note = '{10'd0,   4'd1};  // rest
          3'd3:    note = '{10'd261, 4'd1};  // c4
          3'd4:    note = '{10'd233, 4'd2};  // b3f
          default: note = '{10'd0,   4'd0};
        endcase
      end
      SEC_CHORUS: begin
        last = (index == 3'd4);
        case (index)
          3'd0:    note = '{10'd466, 4'd1};  // b4f
          3'd1:    note = '{10'd415, 4'd1};  // a4f
          3'd2:    note = '{10'd698, 4'd2};  // f5
          3'd3:    note = '{10'd622, 4'd3};  // e5f
          3'd4:    note = '{10'd0,   4'd1};  // rest
          default: note = '{10'd0,   4'd0};
        endcase
      end
      default: begin
        // unused section code plays silence and ends at once
        last = 1'b1;
      end
    endcase
  end

endmodule

/* logic/tone_generator.sv */
module tone_generator
  import music_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [TPM_W-1:0]  ticks_per_milli,
  input  logic [FREQ_W-1:0] note_freq,
  output logic              sound
);

  logic [31:0] acc;       // phase accumulator
  logic [31:0] half_sec;  // clock ticks in half a second
  logic [31:0] acc_next;

  assign half_sec = 32'(ticks_per_milli) * 32'd500;
  assign acc_next = acc + 32'(note_freq);

  // one toggle per half_sec/freq cycles gives freq hz
  always_ff @(posedge clk) begin
    if (rst) begin
      acc   <= '0;
      sound <= 1'b0;
    end else if (note_freq == '0) begin
      sound <= 1'b0;  // silence, acc holds
    end else if (acc >= half_sec) begin
      sound <= ~sound;
      acc   <= acc_next - half_sec;
    end else begin
      acc <= acc_next;
    end
  end

endmodule

/* sim/music_player_checker.sv */
module music_player_checker
  import music_pkg::*;
(
  input logic              clk,
  input logic              rst,
  input logic              milli_tick,
  input logic [FREQ_W-1:0] note_freq,
  input logic              sound
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // failed assertions so far

  tick_single: assert property (@(posedge clk) disable iff (rst)
    milli_tick |=> !milli_tick)
    else begin
      fail_count++;
      $error("milli_tick high on two cycles in a row");
    end

  quiet_after_zero: assert property (@(posedge clk) disable iff (rst)
    (note_freq == '0) |=> !sound)
    else begin
      fail_count++;
      $error("sound high one cycle after note_freq went to zero");
    end

  // zero for two edges, output must be frozen
  no_toggle_zero: assert property (@(posedge clk) disable iff (rst)
    (note_freq == '0 && $past(note_freq) == '0) |=> $stable(sound))
    else begin
      fail_count++;
      $error("sound toggled while note_freq was zero");
    end

endmodule

bind music_player music_player_checker player_chk (
  .clk        (clk),
  .rst        (rst),
  .milli_tick (milli_tick),
  .note_freq  (note_freq),
  .sound      (sound)
);

/* sim/music_player_tb.sv */
module music_player_tb
  import music_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int BEAT_MS  = 3;
  localparam int TPM      = 4;
  localparam int MS_CYC   = TPM + 1;    // cycles per millisecond
  localparam int HALF_SEC = TPM * 500;  // tone accumulator wrap

  logic             clk;
  logic             rst;
  logic [TPM_W-1:0] ticks_per_milli;
  led_t             led;
  logic             sound;

  // song copy with rows for intro verse and chorus
  int song_pitch [3][5] = '{'{554, 622, 0, 415, 0},
                            '{277, 311, 0, 261, 233},
                            '{466, 415, 698, 622, 0}};
  int song_beats [3][5] = '{'{2, 2, 1, 3, 0},
                            '{1, 1, 1, 1, 2},
                            '{1, 1, 2, 3, 1}};
  int song_notes [3]    = '{4, 5, 5};

  int   n_checks;
  int   n_errors;
  int   chk_fails;
  led_t smp_led;       // last mid-cycle sample
  logic smp_sound;
  int   digits_seen[$];

  music_player #(
    .BEAT_MS (BEAT_MS)
  ) uut (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .led             (led),
    .sound           (sound)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int section_of(int part_no);
    case (part_no)
      1, 2:    return 0;
      3, 5:    return 1;
      default: return 2;  // chorus parts
    endcase
  endfunction

  function automatic int play_ms(int sec, int idx);
    return BEAT_MS * song_beats[sec][idx] * ((sec == 1) ? 2 : 1);  // verse doubles
  endfunction

  // both common renderings of six are accepted
  function automatic int seg_to_digit(logic [6:0] seg);
    case (seg)
      7'h06:        return 1;
      7'h5B:        return 2;
      7'h4F:        return 3;
      7'h66:        return 4;
      7'h6D:        return 5;
      7'h7C, 7'h7D: return 6;
      default:      return -1;
    endcase
  endfunction

  // longest expected lap in cycles with one load cycle per note
  function automatic int lap_cycles();
    int total;
    int sec;
    int len;
    total = 0;
    for (int p = 1; p <= 6; p++) begin
      sec = section_of(p);
      for (int i = 0; i < song_notes[sec]; i++) begin
        len = play_ms(sec, i);
        total += (len + 1 + len / 3 + 1) * MS_CYC + 1;
      end
    end
    return total;
  endfunction

  task automatic check_value(string test_name, string what, int expected, int actual,
                             int tol);
    n_checks++;
    assert (actual >= expected - tol && actual <= expected + tol)
      else begin
        n_errors++;
        $display("ERR %s %s expected %0d actual %0d", test_name, what, expected, actual);
      end
  endtask

  task automatic check_range(string test_name, string what, int lo, int hi, int actual);
    n_checks++;
    assert (actual >= lo && actual <= hi)
      else begin
        n_errors++;
        $display("ERR %s %s expected %0d..%0d actual %0d", test_name, what, lo, hi, actual);
      end
  endtask

  task automatic take_sample();
    @(negedge clk);  // mid-cycle where outputs are settled
    smp_led   = led;
    smp_sound = sound;
  endtask

  // runs until the dot changes and credits toggles to the level before them
  task automatic measure_run(output logic run_dot, output int run_cycles,
                             output int run_toggles, output int run_high);
    logic last_sound;
    run_dot     = smp_led.dot;
    run_cycles  = 0;
    run_toggles = 0;
    run_high    = 0;
    while (smp_led.dot == run_dot) begin
      last_sound = smp_sound;
      take_sample();
      run_cycles++;
      if (smp_sound != last_sound) run_toggles++;
      if (smp_sound) run_high++;
    end
  endtask

  task automatic play_note(string test_name, int part_no, int idx, bit check_timing);
    logic run_dot;
    int   cycles;
    int   toggles;
    int   high;
    int   sec;
    int   len;
    int   pitch;
    sec   = section_of(part_no);
    len   = play_ms(sec, idx);
    pitch = song_pitch[sec][idx];
    measure_run(run_dot, cycles, toggles, high);
    if (check_timing) check_value(test_name, "play ms", len, cycles / MS_CYC, 1);
    if (pitch == 0) begin
      check_value(test_name, "rest toggles", 0, toggles, 0);
    end else if (check_timing && sec == 0) begin
      check_range(test_name, "tone toggles", (cycles * pitch) / HALF_SEC - 1,
                  (cycles * pitch + HALF_SEC - 1) / HALF_SEC + 1, toggles);
    end
    measure_run(run_dot, cycles, toggles, high);
    if (check_timing) check_value(test_name, "gap ms", len / 3, cycles / MS_CYC, 1);
    check_value(test_name, "gap sound high", 0, high, 0);  // silent after first cycle
  endtask

  task automatic play_part(string test_name, int part_no, bit check_timing);
    int sec;
    sec = section_of(part_no);
    digits_seen.push_back(seg_to_digit(smp_led.seg));
    for (int i = 0; i < song_notes[sec]; i++) begin
      play_note(test_name, part_no, i, check_timing);
    end
  endtask

  task automatic test_reset();
    @(posedge clk);
    take_sample();
    check_value("reset", "sound", 0, int'(smp_sound), 0);
    check_value("reset", "segments", 6, int'(smp_led.seg), 0);  // digit 1
    @(posedge clk);
    #1;
    rst = 1'b0;
    take_sample();  // still shows the reset state
    check_value("reset", "sound after", 0, int'(smp_sound), 0);
    check_value("reset", "segments after", 6, int'(smp_led.seg), 0);
    check_value("reset", "dot after", 0, int'(smp_led.dot), 0);
  endtask

  task automatic test_note_timing();
    logic run_dot;
    int   cycles;
    int   toggles;
    int   high;
    measure_run(run_dot, cycles, toggles, high);  // load cycle after reset
    for (int p = 1; p <= 3; p++) begin
      play_part("note_timing", p, 1'b1);
    end
  endtask

  task automatic test_part_order();
    for (int p = 4; p <= 6; p++) begin
      play_part("part_order", p, 1'b0);
    end
    digits_seen.push_back(seg_to_digit(smp_led.seg));  // wrapped back
    for (int i = 0; i < digits_seen.size(); i++) begin
      check_value("part_order", $sformatf("digit %0d", i), (i % 6) + 1, digits_seen[i], 0);
    end
  endtask

  initial begin
    int limit_cycles;
    limit_cycles = (2 * lap_cycles() * 3) / 2 + 10;  // two laps with margin
    #(limit_cycles * 10);
    $display("timeout, song not finished after %0d cycles", limit_cycles);
    $display("test failed");
    $finish;
  end

  initial begin
    rst             = 1'b1;
    ticks_per_milli = TPM_W'(TPM);
    n_checks        = 0;
    n_errors        = 0;
    smp_led         = '0;
    smp_sound       = 1'b0;
    test_reset();
    test_note_timing();
    test_part_order();
    chk_fails = uut.player_chk.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors, chk_fails);
    if (n_errors == 0 && chk_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
